// File: verilog/cgra_acc_pkg.sv
`default_nettype none

package cgra_acc_pkg;

  // ==============================
  // widths.
  // ==============================
  localparam int WIDE_W     = 64;
  localparam int LANE_W     = 16;
  localparam int LANES      = WIDE_W / LANE_W;
  localparam int LANE_SEL_W = $clog2(LANES);
  localparam int NUM_RD_CH  = 2;
  localparam int QTD_W      = 16;

  typedef logic [LANE_W-1:0] lane_t;

  typedef enum logic [1:0] {
    OP_ADD = 2'd0,
    OP_SUB = 2'd1,
    OP_MUL = 2'd2, // low half of product.
    OP_MAX = 2'd3  // unsigned.
  } pe_op_t;

  // configuration word, qtd at the bottom.
  typedef struct packed {
    logic [WIDE_W-QTD_W-2-1:0] rsvd;
    pe_op_t                    op;
    logic [QTD_W-1:0]          qtd;
  } conf_t;

  // ==============================
  // host channels.
  // ==============================
  typedef struct packed {
    logic              available;
    logic              data_valid;
    logic [WIDE_W-1:0] data;
  } rd_in_t;

  typedef struct packed {
    logic available;
  } wr_in_t;

  typedef struct packed {
    logic              request;
    logic [WIDE_W-1:0] data;
  } wr_out_t;

endpackage

`default_nettype wire

// File: verilog/cgra_fetch_data.sv
`default_nettype none

module cgra_fetch_data
  import cgra_acc_pkg::*;
(
  input  wire         clk,
  input  wire         rst,
  input  wire         en,
  input  wire rd_in_t rd_in,
  output logic        request_read,
  input  wire         pop,
  output logic        available_pop,
  output lane_t       data_out
);

  logic [WIDE_W-1:0]     word;
  logic [LANE_SEL_W-1:0] idx;
  logic                  full;
  logic                  pending;
  logic                  word_in;

  // one outstanding read at a time.
  assign request_read  = en && !full && !pending && rd_in.available;
  assign word_in       = pending && rd_in.data_valid;
  assign available_pop = full;
  assign data_out      = word[idx*LANE_W +: LANE_W];

  always_ff @(posedge clk) begin
    if (rst) begin
      pending <= 1'b0;
      full    <= 1'b0;
      idx     <= '0;
    end else begin
      if (request_read) begin
        pending <= 1'b1;
      end else if (word_in) begin
        pending <= 1'b0;
      end

      if (!en) begin
        // late data of a finished job is thrown away.
        full <= 1'b0;
        idx  <= '0;
      end else if (word_in) begin
        full <= 1'b1;
        idx  <= '0;
      end else if (pop && full) begin
        if (idx == LANE_SEL_W'(LANES - 1)) begin
          full <= 1'b0; // last lane gone.
          idx  <= '0;
        end else begin
          idx <= idx + 1'b1;
        end
      end
    end
  end

  always_ff @(posedge clk) begin
    if (word_in) begin
      word <= rd_in.data;
    end
  end

endmodule

`default_nettype wire

// File: verilog/cgra_dispatch_data.sv
`default_nettype none

module cgra_dispatch_data
  import cgra_acc_pkg::*;
(
  input  wire         clk,
  input  wire         rst,
  input  wire         en,
  input  wire         push,
  input  wire lane_t  data_in,
  output logic        available_push,
  input  wire wr_in_t wr_in,
  output wr_out_t     wr_out
);

  logic [WIDE_W-1:0]     word;
  logic [LANE_SEL_W-1:0] idx;
  logic                  full;
  logic                  take;

  // a complete word blocks the PE array until it is written.
  assign available_push = !full;
  assign take           = en && push && !full;

  assign wr_out.request = full && wr_in.available;
  assign wr_out.data    = word;

  always_ff @(posedge clk) begin
    if (rst) begin
      full <= 1'b0;
      idx  <= '0;
    end else if (!en) begin
      full <= 1'b0; // partial word dropped.
      idx  <= '0;
    end else if (wr_out.request) begin
      full <= 1'b0;
    end else if (take) begin
      if (idx == LANE_SEL_W'(LANES - 1)) begin
        full <= 1'b1;
        idx  <= '0;
      end else begin
        idx <= idx + 1'b1;
      end
    end
  end

  // lane 0 lands in the low bits.
  always_ff @(posedge clk) begin
    if (take) begin
      word[idx*LANE_W +: LANE_W] <= data_in;
    end
  end

endmodule

`default_nettype wire

// File: verilog/cgra_pe_conf_control.sv
`default_nettype none

module cgra_pe_conf_control
  import cgra_acc_pkg::*;
(
  input  wire         clk,
  input  wire         rst,
  input  wire         start,
  input  wire rd_in_t rd_in,
  output logic        request_read,
  output conf_t       conf,
  output logic        conf_done
);

  typedef enum logic [1:0] {
    CONF_IDLE,
    CONF_REQ,
    CONF_WAIT
  } conf_state_t;

  conf_state_t state;
  logic        conf_in;

  assign request_read = (state == CONF_REQ) && rd_in.available;
  assign conf_in      = (state == CONF_WAIT) && rd_in.data_valid;

  always_ff @(posedge clk) begin
    if (rst) begin
      state     <= CONF_IDLE;
      conf_done <= 1'b0;
    end else begin
      conf_done <= conf_in;
      case (state)
        CONF_IDLE: if (start) state <= CONF_REQ;
        CONF_REQ:  if (rd_in.available) state <= CONF_WAIT; // request sent.
        CONF_WAIT: if (rd_in.data_valid) state <= CONF_IDLE;
        default:   state <= CONF_IDLE;
      endcase
    end
  end

  // held until the next job reloads it.
  always_ff @(posedge clk) begin
    if (conf_in) begin
      conf <= conf_t'(rd_in.data);
    end
  end

endmodule

`default_nettype wire

// File: verilog/cgra_control_exec.sv
`default_nettype none

module cgra_control_exec
  import cgra_acc_pkg::*;
(
  input  wire                   clk,
  input  wire                   rst,
  input  wire                   conf_done,
  input  wire [QTD_W-1:0]       qtd,
  input  wire                   word_written,
  output logic [NUM_RD_CH-1:0]  en_fetch,
  output logic                  en_pe,
  output logic                  en_dispatch,
  output logic                  done
);

  typedef enum logic {
    EXEC_IDLE,
    EXEC_RUN
  } exec_state_t;

  exec_state_t      state;
  logic [QTD_W-1:0] cnt;
  logic             running;

  assign running     = state == EXEC_RUN;
  assign en_fetch    = {NUM_RD_CH{running}};
  assign en_pe       = running;
  assign en_dispatch = running;

  always_ff @(posedge clk) begin
    if (rst) begin
      state <= EXEC_IDLE;
      cnt   <= '0;
      done  <= 1'b0;
    end else begin
      done <= 1'b0;
      case (state)
        EXEC_IDLE: begin
          if (conf_done) begin
            cnt <= '0;
            if (qtd == '0) begin
              done <= 1'b1; // empty job.
            end else begin
              state <= EXEC_RUN;
            end
          end
        end
        EXEC_RUN: begin
          if (word_written) begin
            if (cnt == qtd - 1'b1) begin
              // last word out, shut the datapath down.
              state <= EXEC_IDLE;
              cnt   <= '0;
              done  <= 1'b1;
            end else begin
              cnt <= cnt + 1'b1;
            end
          end
        end
        default: state <= EXEC_IDLE;
      endcase
    end
  end

endmodule

`default_nettype wire

// File: verilog/cgra_pe_array.sv
`default_nettype none

module cgra_pe_array
  import cgra_acc_pkg::*;
(
  input  wire                  clk,
  input  wire                  rst,
  input  wire                  en,
  input  wire pe_op_t          op,
  input  wire [NUM_RD_CH-1:0]  available_pop,
  output logic [NUM_RD_CH-1:0] pop,
  input  wire lane_t           lane_a,
  input  wire lane_t           lane_b,
  input  wire                  available_push,
  output logic                 push,
  output lane_t                data_out
);

  logic  advance;
  logic  take;
  logic  s1_valid;
  lane_t s1_a;
  lane_t s1_b;
  logic  s2_valid;
  lane_t s2_res;

  function automatic lane_t pe_calc(input pe_op_t f_op, input lane_t a, input lane_t b);
    case (f_op)
      OP_ADD:  pe_calc = a + b;
      OP_SUB:  pe_calc = a - b;
      OP_MUL:  pe_calc = a * b;
      OP_MAX:  pe_calc = (a > b) ? a : b;
      default: pe_calc = '0;
    endcase
  endfunction

  // ==============================
  // flow control.
  // ==============================
  // a full dispatch buffer freezes both stages.
  assign advance  = en && available_push;
  assign take     = advance && (&available_pop);
  assign pop      = {NUM_RD_CH{take}}; // both channels together.
  assign push     = advance && s2_valid;
  assign data_out = s2_res;

  always_ff @(posedge clk) begin
    if (rst || !en) begin
      s1_valid <= 1'b0;
      s2_valid <= 1'b0;
    end else if (advance) begin
      s1_valid <= take;
      s2_valid <= s1_valid;
    end
  end

  // ==============================
  // datapath.
  // ==============================
  always_ff @(posedge clk) begin
    if (take) begin
      s1_a <= lane_a;
      s1_b <= lane_b;
    end
    if (advance && s1_valid) begin
      s2_res <= pe_calc(op, s1_a, s1_b); // channel 0 on the left.
    end
  end

endmodule

`default_nettype wire

// File: verilog/cgra_acc.sv
`default_nettype none

module cgra_acc
  import cgra_acc_pkg::*;
(
  input  wire                  clk,
  input  wire                  rst,
  input  wire                  start,
  input  wire rd_in_t          rd_in [NUM_RD_CH],
  output logic [NUM_RD_CH-1:0] request_read,
  input  wire wr_in_t          wr_in,
  output wr_out_t              wr_out,
  output logic                 done
);

  conf_t                conf;
  logic                 conf_done;
  logic                 conf_req_rd;
  logic [NUM_RD_CH-1:0] fetch_req_rd;
  logic [NUM_RD_CH-1:0] en_fetch;
  logic                 en_pe;
  logic                 en_dispatch;
  logic [NUM_RD_CH-1:0] available_pop;
  logic [NUM_RD_CH-1:0] pop;
  lane_t                fetch_lane [NUM_RD_CH];
  logic                 available_push;
  logic                 push;
  lane_t                pe_lane;

  // channel 0 is shared with the configuration fetch.
  assign request_read = fetch_req_rd | {{(NUM_RD_CH-1){1'b0}}, conf_req_rd};

  // ==============================
  // control.
  // ==============================
  cgra_pe_conf_control control_pe_conf (
    .clk          (clk),
    .rst          (rst),
    .start        (start),
    .rd_in        (rd_in[0]),
    .request_read (conf_req_rd),
    .conf         (conf),
    .conf_done    (conf_done)
  );

  cgra_control_exec control_exec (
    .clk          (clk),
    .rst          (rst),
    .conf_done    (conf_done),
    .qtd          (conf.qtd),
    .word_written (wr_out.request),
    .en_fetch     (en_fetch),
    .en_pe        (en_pe),
    .en_dispatch  (en_dispatch),
    .done         (done)
  );

  // ==============================
  // datapath.
  // ==============================
  for (genvar ch = 0; ch < NUM_RD_CH; ch++) begin : inst_fetch_data
    cgra_fetch_data fetch_data (
      .clk           (clk),
      .rst           (rst),
      .en            (en_fetch[ch]),
      .rd_in         (rd_in[ch]),
      .request_read  (fetch_req_rd[ch]),
      .pop           (pop[ch]),
      .available_pop (available_pop[ch]),
      .data_out      (fetch_lane[ch])
    );
  end

  cgra_pe_array pe_array (
    .clk            (clk),
    .rst            (rst),
    .en             (en_pe),
    .op             (conf.op),
    .available_pop  (available_pop),
    .pop            (pop),
    .lane_a         (fetch_lane[0]),
    .lane_b         (fetch_lane[1]),
    .available_push (available_push),
    .push           (push),
    .data_out       (pe_lane)
  );

  cgra_dispatch_data dispatch_data (
    .clk            (clk),
    .rst            (rst),
    .en             (en_dispatch),
    .push           (push),
    .data_in        (pe_lane),
    .available_push (available_push),
    .wr_in          (wr_in),
    .wr_out         (wr_out)
  );

endmodule

`default_nettype wire

// File: sim/cgra_acc_asserts.sv
`default_nettype none

module cgra_acc_asserts
  import cgra_acc_pkg::*;
(
  input wire                 clk,
  input wire                 rst,
  input wire rd_in_t         rd_in [NUM_RD_CH],
  input wire [NUM_RD_CH-1:0] request_read,
  input wire wr_in_t         wr_in,
  input wire wr_out_t        wr_out,
  input wire                 done,
  input wire                 en_dispatch
);

  // ==============================
  // host handshakes.
  // ==============================
  for (genvar ch = 0; ch < NUM_RD_CH; ch++) begin : rd_checks
    rd_req_avail: assert property (
      @(posedge clk) disable iff (rst) request_read[ch] |-> rd_in[ch].available
    ) else $error("read request on channel %0d while unavailable", ch);
  end

  wr_req_avail: assert property (
    @(posedge clk) disable iff (rst) wr_out.request |-> wr_in.available
  ) else $error("write request while host write channel unavailable");

  // ==============================
  // job control.
  // ==============================
  done_pulse: assert property (
    @(posedge clk) disable iff (rst) done |=> !done
  ) else $error("done longer than one cycle");

  no_idle_write: assert property (
    @(posedge clk) disable iff (rst) wr_out.request |-> en_dispatch
  ) else $error("write request while accelerator idle");

endmodule

bind cgra_acc cgra_acc_asserts asserts (
  .clk          (clk),
  .rst          (rst),
  .rd_in        (rd_in),
  .request_read (request_read),
  .wr_in        (wr_in),
  .wr_out       (wr_out),
  .done         (done),
  .en_dispatch  (en_dispatch)
);

`default_nettype wire

// File: sim/cgra_acc_tb.sv
`default_nettype none

module cgra_acc_tb
  import cgra_acc_pkg::*;
();

  localparam int unsigned SEED           = 32'hf458_77ba;
  localparam int          MEM_DEPTH      = 64;
  localparam int          PTR_W          = $clog2(MEM_DEPTH);
  localparam int          TOTAL_QTD      = 38; // sum of all job lengths.
  localparam int          TIMEOUT_CYCLES = TOTAL_QTD * 64 + 2000;

  logic                 clk = 1'b0;
  logic                 rst;
  logic                 start;
  rd_in_t               rd_in [NUM_RD_CH] = '{default: '0};
  logic [NUM_RD_CH-1:0] request_read;
  wr_in_t               wr_in = '0;
  wr_out_t              wr_out;
  logic                 done;

  logic [WIDE_W-1:0] rd_mem [NUM_RD_CH][MEM_DEPTH];
  logic [PTR_W-1:0]  rd_ptr [NUM_RD_CH];
  logic              busy [NUM_RD_CH];
  int unsigned       wait_cnt [NUM_RD_CH];
  int unsigned       rd_avail_pct;
  int unsigned       rd_lat_max;
  int unsigned       wr_stall_max;
  int unsigned       wr_hold = 0;
  logic [WIDE_W-1:0] exp_words [MEM_DEPTH];
  int                exp_qtd;
  int                wr_idx = 0;
  int                done_cnt = 0;
  logic              done_prev = 1'b0;
  int                cycle_cnt = 0;
  string             test_name;

  always #10 clk = ~clk;

  cgra_acc DUT (
    .clk          (clk),
    .rst          (rst),
    .start        (start),
    .rd_in        (rd_in),
    .request_read (request_read),
    .wr_in        (wr_in),
    .wr_out       (wr_out),
    .done         (done)
  );

  task automatic fail_run(input string why);
    $display("%s", why);
    $display("TESTS FAILED");
    $fatal(1);
  endtask

  task automatic check(input string name, input logic [WIDE_W-1:0] expected,
                       input logic [WIDE_W-1:0] actual);
    if (actual !== expected) begin
      fail_run($sformatf("Error: test %s expected %h actual %h", name, expected, actual));
    end
  endtask

  // lane 0 sits in the low bits.
  function automatic logic [WIDE_W-1:0] expected_word(input pe_op_t op,
                                                      input logic [WIDE_W-1:0] a,
                                                      input logic [WIDE_W-1:0] b);
    logic [WIDE_W-1:0]   res;
    logic [LANE_W-1:0]   la;
    logic [LANE_W-1:0]   lb;
    logic [2*LANE_W-1:0] prod;
    res = '0;
    for (int i = 0; i < LANES; i++) begin
      la   = a[i*LANE_W +: LANE_W];
      lb   = b[i*LANE_W +: LANE_W];
      prod = (2*LANE_W)'(la) * (2*LANE_W)'(lb);
      case (op)
        OP_ADD:  res[i*LANE_W +: LANE_W] = la + lb;
        OP_SUB:  res[i*LANE_W +: LANE_W] = la - lb;
        OP_MUL:  res[i*LANE_W +: LANE_W] = prod[LANE_W-1:0];
        default: res[i*LANE_W +: LANE_W] = (la >= lb) ? la : lb;
      endcase
    end
    return res;
  endfunction

  function automatic logic [WIDE_W-1:0] fill_word(input int ch, input int addr);
    return {16'(ch + 1), 16'(addr), ~16'(addr), 16'hc3a5 ^ 16'(addr * 7)};
  endfunction

  // ==============================
  // host model.
  // ==============================
  always @(posedge clk) begin : host_read
    int unsigned lat;
    logic        serve;
    for (int ch = 0; ch < NUM_RD_CH; ch++) begin
      serve = 1'b0;
      rd_in[ch].available  <= $urandom_range(99) < rd_avail_pct;
      rd_in[ch].data_valid <= 1'b0;
      if (rst) begin
        busy[ch]   <= 1'b0;
        rd_ptr[ch] <= '0;
      end else if (start) begin
        rd_ptr[ch] <= '0; // every job starts at address 0.
      end else if (request_read[ch]) begin
        if (!rd_in[ch].available || busy[ch]) begin
          fail_run($sformatf("read request on channel %0d while unavailable or busy", ch));
        end
        lat = $urandom_range(rd_lat_max, 1);
        if (lat == 1) begin
          serve = 1'b1;
        end else begin
          busy[ch]     <= 1'b1;
          wait_cnt[ch] <= lat - 2;
        end
      end else if (busy[ch]) begin
        if (wait_cnt[ch] == 0) begin
          serve = 1'b1;
          busy[ch] <= 1'b0;
        end else begin
          wait_cnt[ch] <= wait_cnt[ch] - 1;
        end
      end
      if (serve) begin
        rd_in[ch].data_valid <= 1'b1;
        rd_in[ch].data       <= rd_mem[ch][rd_ptr[ch]];
        rd_ptr[ch]           <= rd_ptr[ch] + PTR_W'(1);
      end
    end
  end

  always @(posedge clk) begin : host_write
    if (rst || wr_stall_max == 0) begin
      wr_in.available <= !rst;
      wr_hold         <= 0;
    end else if (wr_hold == 0) begin
      wr_in.available <= !wr_in.available;
      // long stalls and short open windows.
      wr_hold <= wr_in.available ? $urandom_range(wr_stall_max, 1) : $urandom_range(4, 1);
    end else begin
      wr_hold <= wr_hold - 1;
    end
  end

  // ==============================
  // compare and watchdog.
  // ==============================
  always @(posedge clk) begin : compare_writes
    if (!rst) begin
      if (wr_out.request) begin
        if (!wr_in.available) begin
          fail_run("write request while the host write channel was unavailable");
        end else if (start || wr_idx >= exp_qtd) begin
          fail_run($sformatf("unexpected write in test %s after %0d words", test_name, wr_idx));
        end else begin
          check(test_name, exp_words[wr_idx], wr_out.data);
          wr_idx <= wr_idx + 1;
        end
      end
      if (start) begin
        wr_idx <= 0;
      end
      if (done && done_prev) begin
        fail_run("done stayed high for more than one cycle");
      end
      if (done) begin
        // only words written before done count.
        check({test_name, "_count"}, WIDE_W'(exp_qtd), WIDE_W'(wr_idx));
        done_cnt <= done_cnt + 1;
      end
      done_prev <= done;
    end
  end

  always @(posedge clk) begin : watchdog
    cycle_cnt <= cycle_cnt + 1;
    if (cycle_cnt == TIMEOUT_CYCLES) begin
      fail_run($sformatf("timeout, the run did not finish within %0d cycles", TIMEOUT_CYCLES));
    end
  end

  task automatic run_job(input string name, input pe_op_t op, input int qtd,
                         input int unsigned avail_pct, input int unsigned lat_max,
                         input int unsigned stall_max);
    conf_t             conf;
    logic [WIDE_W-1:0] a;
    logic [WIDE_W-1:0] b;
    int                done_before;
    @(negedge clk);
    test_name    = name;
    rd_avail_pct = avail_pct;
    rd_lat_max   = lat_max;
    wr_stall_max = stall_max;
    for (int ch = 0; ch < NUM_RD_CH; ch++) begin
      for (int addr = 0; addr < MEM_DEPTH; addr++) begin
        rd_mem[ch][addr] = fill_word(ch, addr);
      end
    end
    conf         = '0;
    conf.op      = op;
    conf.qtd     = QTD_W'(qtd);
    rd_mem[0][0] = conf;
    for (int i = 0; i < qtd; i++) begin
      a              = {$urandom, $urandom};
      b              = {$urandom, $urandom};
      rd_mem[0][i+1] = a; // behind the configuration word.
      rd_mem[1][i]   = b;
      exp_words[i]   = expected_word(op, a, b);
    end
    exp_qtd     = qtd;
    done_before = done_cnt;
    @(posedge clk);
    start <= 1'b1;
    @(posedge clk);
    start <= 1'b0;
    while (done_cnt == done_before) begin
      @(posedge clk);
    end
    repeat (20) @(posedge clk); // quiet time after done.
  endtask

  initial begin : main
    void'($urandom(SEED));
    rst          = 1'b1;
    start        = 1'b0;
    rd_avail_pct = 100;
    rd_lat_max   = 1;
    wr_stall_max = 0;
    exp_qtd      = 0;
    test_name    = "reset_idle";
    repeat (16) @(posedge clk);
    rst <= 1'b0;

    repeat (40) begin
      @(negedge clk);
      check("reset_idle", '0, WIDE_W'({request_read, wr_out.request, done}));
    end

    run_job("op_add", OP_ADD, 4, 100, 1, 0);
    run_job("op_sub", OP_SUB, 4, 100, 1, 0);
    run_job("op_mul", OP_MUL, 4, 100, 1, 0);
    run_job("op_max", OP_MAX, 4, 100, 1, 0);
    run_job("backpressure", OP_ADD, 6, 100, 1, 30);
    run_job("read_latency", OP_SUB, 8, 60, 4, 0);
    run_job("empty_job", OP_MAX, 0, 100, 1, 0);
    run_job("back_to_back_a", OP_MUL, 3, 70, 4, 6);
    run_job("back_to_back_b", OP_MAX, 5, 70, 4, 6);

    repeat (5) @(posedge clk);
    $display("TESTS PASSED");
    $finish;
  end

endmodule

`default_nettype wire

// File: src.f
verilog/cgra_acc_pkg.sv
verilog/cgra_fetch_data.sv
verilog/cgra_dispatch_data.sv
verilog/cgra_pe_conf_control.sv
verilog/cgra_control_exec.sv
verilog/cgra_pe_array.sv
verilog/cgra_acc.sv
sim/cgra_acc_asserts.sv
sim/cgra_acc_tb.sv

// File: Makefile
TOP = cgra_acc_tb

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing --assert -Wno-fatal --top-module $(TOP) -f src.f -o $(TOP)

run: compile
	./obj_dir/$(TOP) | tee sim.log
	@if grep -q "TESTS FAILED" sim.log; then echo "simulation reported a failure"; exit 1; fi
	@grep -q "TESTS PASSED" sim.log || (echo "simulation ended without a result"; exit 1)

clean:
	rm -rf obj_dir sim.log
